//--- source/core_pkg.sv
// -----------------------------------------------
// Shared definitions for the accumulator core
// Widths, opcodes, ALU operations and bus structs
// -----------------------------------------------
`default_nettype none

package core_pkg;

// -----------------------------------------------
// Widths
// -----------------------------------------------
localparam int OPCODE_W  = 7;
localparam int OPERAND_W = 9;
localparam int INSTR_W   = OPCODE_W + OPERAND_W;
localparam int DATA_W    = 16;
localparam int IADDR_W   = 9;
localparam int DADDR_W   = 9;
// Port number sits in the low operand bits
localparam int PORT_W    = 3;

// Default stack depths for the top level
localparam int RSTACK_DEPTH = 8;
localparam int DSTACK_DEPTH = 8;

// -----------------------------------------------
// Scalar types
// -----------------------------------------------
typedef logic [DATA_W-1:0]  data_t;
typedef logic [IADDR_W-1:0] iaddr_t;
typedef logic [PORT_W-1:0]  port_t;

// Instruction set, NOP must stay at code zero
typedef enum logic [OPCODE_W-1:0] {
	NOP, LOD, SET, PSH, POP, INN, OUT,
	ADD, SUB, AND, ORR, XOR, SHL, SHR,
	JMP, JIZ, CAL, RET
} opcode_t;

// ALU function, shifts use operand bits 3:0
typedef enum logic [3:0] {
	ALU_PASS_A, ALU_PASS_B, ALU_ADD, ALU_SUB,
	ALU_AND, ALU_ORR, ALU_XOR, ALU_SHL, ALU_SHR
} alu_op_t;

// Where the ALU operand comes from
typedef enum logic [1:0] {
	SRC_MEM, SRC_IO, SRC_STACK
} src_sel_t;

// -----------------------------------------------
// Packed structs
// -----------------------------------------------
typedef struct packed {
	opcode_t               opcode;
	logic [OPERAND_W-1:0]  operand;
} instr_t;

// Registered decode output for the execute stage
typedef struct packed {
	alu_op_t              alu_op;
	src_sel_t             src;
	logic                 push;
	logic                 pop;
	logic                 mem_wr;
	logic                 out_en;
	// Store address, or port in the low bits
	logic [DADDR_W-1:0]   waddr;
} exec_ctrl_t;

typedef struct packed {
	logic  req;
	port_t port;
} io_rd_t;

typedef struct packed {
	logic               en;
	logic [DADDR_W-1:0] addr;
	data_t              data;
} dmem_wr_t;

typedef struct packed {
	logic  en;
	port_t port;
	data_t data;
} io_wr_t;

endpackage

`default_nettype wire

//--- source/lifo.sv
// -----------------------------------------------
// Stack store for return addresses and data
// Pointer based LIFO with a combinational top
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              push,
	input  wire              pop,
	input  wire [WIDTH-1:0]  din,
	output logic [WIDTH-1:0] top
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic [WIDTH-1:0] mem [DEPTH];

// Pointer names the next free entry
logic [PTR_W-1:0] ptr;
logic [PTR_W-1:0] ptr_up;
logic [PTR_W-1:0] ptr_dn;

// Wrap at both ends, also for odd depths
assign ptr_up = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
assign ptr_dn = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		ptr <= '0;
	end else if (push) begin
		ptr <= ptr_up;
	end else if (pop) begin
		ptr <= ptr_dn;
	end
end

// Write into the free slot
always_ff @(posedge clk) begin
	if (push) begin
		mem[ptr] <= din;
	end
end

// Last pushed entry, no output register
assign top = mem[ptr_dn];

endmodule

`default_nettype wire

//--- source/alu.sv
// -----------------------------------------------
// Integer ALU
// Accumulator against the selected operand
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire core_pkg::alu_op_t op,
	input  wire core_pkg::data_t   a,
	input  wire core_pkg::data_t   b,
	output core_pkg::data_t        y
);

import core_pkg::*;

// Shift amount, low operand nibble
logic [3:0] shamt;

assign shamt = b[3:0];

always_comb begin
	unique case (op)
		ALU_PASS_A: y = a;
		ALU_PASS_B: y = b;
		// Wraps modulo 2^16
		ALU_ADD:    y = a + b;
		ALU_SUB:    y = a - b;
		ALU_AND:    y = a & b;
		ALU_ORR:    y = a | b;
		ALU_XOR:    y = a ^ b;
		// Logical shifts, zero fill
		ALU_SHL:    y = a << shamt;
		ALU_SHR:    y = a >> shamt;
		default:    y = a;
	endcase
end

endmodule

`default_nettype wire

//--- source/instr_fetch.sv
// -----------------------------------------------
// Instruction fetch
// Program counter, branch redirect, return stack
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
	parameter int RSTACK_DEPTH = 8
) (
	input  wire                    clk,
	input  wire                    rst,
	input  wire core_pkg::instr_t  instr,
	input  wire                    is_zero,
	output core_pkg::iaddr_t       instr_addr,
	output core_pkg::instr_t       dec_instr
);

import core_pkg::*;

localparam instr_t NOP_WORD = '{opcode: NOP, operand: '0};

// Address of the word after the one now decoding
iaddr_t pc;
// Low until the first real word returns
logic   word_valid;
iaddr_t ret_addr;
logic   rs_push;
logic   rs_pop;

// -----------------------------------------------
// Word qualification
// -----------------------------------------------
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		word_valid <= 1'b0;
	end else begin
		word_valid <= 1'b1;
	end
end

// Word seen right after reset is stale
assign dec_instr = word_valid ? instr : NOP_WORD;

// -----------------------------------------------
// Next fetch address
// -----------------------------------------------
// Redirect in the decode cycle, no bubble
always_comb begin
	unique case (dec_instr.opcode)
		JMP, CAL: instr_addr = dec_instr.operand[IADDR_W-1:0];
		JIZ: begin
			// Zero flag of the instruction now executing
			if (is_zero) begin
				instr_addr = dec_instr.operand[IADDR_W-1:0];
			end else begin
				instr_addr = pc;
			end
		end
		RET:     instr_addr = ret_addr;
		default: instr_addr = pc;
	endcase
end

// Sequential fetch follows the address just issued
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		pc <= '0;
	end else begin
		pc <= instr_addr + 1'b1;
	end
end

// -----------------------------------------------
// Return stack
// -----------------------------------------------
// pc already points past the CAL
assign rs_push = (dec_instr.opcode == CAL);
assign rs_pop  = (dec_instr.opcode == RET);

lifo #(
	.DEPTH (RSTACK_DEPTH),
	.WIDTH (IADDR_W)
) u_rstack (
	.clk  (clk),
	.rst  (rst),
	.push (rs_push),
	.pop  (rs_pop),
	.din  (pc),
	.top  (ret_addr)
);

endmodule

`default_nettype wire

//--- source/instr_dec.sv
// -----------------------------------------------
// Instruction decoder
// Issues memory and I/O reads, registers controls
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_dec (
	input  wire                          clk,
	input  wire                          rst,
	input  wire core_pkg::instr_t        dec_instr,
	output logic [core_pkg::DADDR_W-1:0] dmem_rd_addr,
	output core_pkg::io_rd_t             io_rd,
	output core_pkg::exec_ctrl_t         ctrl
);

import core_pkg::*;

// Accumulator passes through, no strobes
localparam exec_ctrl_t CTRL_NOP = '{
	alu_op: ALU_PASS_A,
	src:    SRC_MEM,
	push:   1'b0,
	pop:    1'b0,
	mem_wr: 1'b0,
	out_en: 1'b0,
	waddr:  '0
};

exec_ctrl_t ctrl_d;

// -----------------------------------------------
// Read side, same cycle as decode
// -----------------------------------------------
// Direct address, data returns in execute
assign dmem_rd_addr = dec_instr.operand[DADDR_W-1:0];

assign io_rd = '{
	req:  (dec_instr.opcode == INN),
	port: dec_instr.operand[PORT_W-1:0]
};

// -----------------------------------------------
// Control mapping
// -----------------------------------------------
always_comb begin
	ctrl_d = CTRL_NOP;
	unique case (dec_instr.opcode)
		LOD: ctrl_d.alu_op = ALU_PASS_B;
		SET: begin
			// Stores the accumulator, acc unchanged
			ctrl_d.mem_wr = 1'b1;
			ctrl_d.waddr  = dec_instr.operand[DADDR_W-1:0];
		end
		PSH: ctrl_d.push = 1'b1;
		POP: begin
			ctrl_d.alu_op = ALU_PASS_B;
			ctrl_d.src    = SRC_STACK;
			ctrl_d.pop    = 1'b1;
		end
		INN: begin
			ctrl_d.alu_op = ALU_PASS_B;
			ctrl_d.src    = SRC_IO;
		end
		OUT: begin
			ctrl_d.out_en = 1'b1;
			ctrl_d.waddr  = dec_instr.operand[DADDR_W-1:0];
		end
		// Two operand ops, memory operand
		ADD: ctrl_d.alu_op = ALU_ADD;
		SUB: ctrl_d.alu_op = ALU_SUB;
		AND: ctrl_d.alu_op = ALU_AND;
		ORR: ctrl_d.alu_op = ALU_ORR;
		XOR: ctrl_d.alu_op = ALU_XOR;
		SHL: ctrl_d.alu_op = ALU_SHL;
		SHR: ctrl_d.alu_op = ALU_SHR;
		// Branches handled in fetch
		default: ctrl_d = CTRL_NOP;
	endcase
end

// Pipeline register into execute
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		ctrl <= CTRL_NOP;
	end else begin
		ctrl <= ctrl_d;
	end
end

endmodule

`default_nettype wire

//--- source/exec_unit.sv
// -----------------------------------------------
// Execute stage
// Operand select, ALU, accumulator, data stack
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
	parameter int DSTACK_DEPTH = 8
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire core_pkg::exec_ctrl_t ctrl,
	input  wire core_pkg::data_t      dmem_rd_data,
	input  wire core_pkg::data_t      io_in,
	output logic                      is_zero,
	output core_pkg::dmem_wr_t        dmem_wr,
	output core_pkg::io_wr_t          io_wr
);

import core_pkg::*;

data_t io_q;
data_t acc;
data_t opnd;
data_t result;
data_t stack_top;

// Port value sampled at the end of decode
always_ff @(posedge clk) begin
	io_q <= io_in;
end

// -----------------------------------------------
// Operand and ALU
// -----------------------------------------------
always_comb begin
	unique case (ctrl.src)
		SRC_IO:    opnd = io_q;
		SRC_STACK: opnd = stack_top;
		default:   opnd = dmem_rd_data;
	endcase
end

alu u_alu (
	.op (ctrl.alu_op),
	.a  (acc),
	.b  (opnd),
	.y  (result)
);

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		acc <= '0;
	end else begin
		acc <= result;
	end
end

// Flag for a JIZ now in decode
assign is_zero = (result == '0);

// Data stack, pushes the current accumulator
lifo #(
	.DEPTH (DSTACK_DEPTH),
	.WIDTH (DATA_W)
) u_dstack (
	.clk  (clk),
	.rst  (rst),
	.push (ctrl.push),
	.pop  (ctrl.pop),
	.din  (acc),
	.top  (stack_top)
);

// -----------------------------------------------
// Write strobes, value before this update
// -----------------------------------------------
assign dmem_wr = '{en: ctrl.mem_wr, addr: ctrl.waddr, data: acc};
assign io_wr   = '{en: ctrl.out_en, port: ctrl.waddr[PORT_W-1:0], data: acc};

endmodule

`default_nettype wire

//--- source/core.sv
// -----------------------------------------------
// Accumulator core top level
// Fetch, decode and execute, two words in flight
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter int RSTACK_DEPTH = core_pkg::RSTACK_DEPTH,
	parameter int DSTACK_DEPTH = core_pkg::DSTACK_DEPTH
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire core_pkg::instr_t        instr,
	input  wire core_pkg::data_t         dmem_rd_data,
	input  wire core_pkg::data_t         io_in,
	output core_pkg::iaddr_t             instr_addr,
	output logic [core_pkg::DADDR_W-1:0] dmem_rd_addr,
	output core_pkg::dmem_wr_t           dmem_wr,
	output core_pkg::io_rd_t             io_rd,
	output core_pkg::io_wr_t             io_wr
);

import core_pkg::*;

instr_t     dec_instr;
exec_ctrl_t ctrl;
// From the executing instruction back to fetch
logic       is_zero;

instr_fetch #(
	.RSTACK_DEPTH (RSTACK_DEPTH)
) u_fetch (
	.clk        (clk),
	.rst        (rst),
	.instr      (instr),
	.is_zero    (is_zero),
	.instr_addr (instr_addr),
	.dec_instr  (dec_instr)
);

instr_dec u_dec (
	.clk          (clk),
	.rst          (rst),
	.dec_instr    (dec_instr),
	.dmem_rd_addr (dmem_rd_addr),
	.io_rd        (io_rd),
	.ctrl         (ctrl)
);

exec_unit #(
	.DSTACK_DEPTH (DSTACK_DEPTH)
) u_exec (
	.clk          (clk),
	.rst          (rst),
	.ctrl         (ctrl),
	.dmem_rd_data (dmem_rd_data),
	.io_in        (io_in),
	.is_zero      (is_zero),
	.dmem_wr      (dmem_wr),
	.io_wr        (io_wr)
);

endmodule

`default_nettype wire

//--- include/core_tb_ref.svh
// -----------------------------------------------
// Testbench program builders and ISA reference
// Runs a program in plain order for expected I/O
// -----------------------------------------------
`ifndef CORE_TB_REF_SVH
`define CORE_TB_REF_SVH

typedef core_pkg::instr_t prog_t[$];
typedef core_pkg::data_t  dmem_img_t[2**core_pkg::DADDR_W];
typedef core_pkg::port_t  port_q_t[$];

// One expected port write
typedef struct packed {
	core_pkg::port_t port;
	core_pkg::data_t data;
} io_exp_t;

typedef io_exp_t io_exp_q_t[$];

// -----------------------------------------------
// Program builders
// -----------------------------------------------
function automatic core_pkg::instr_t ins(input core_pkg::opcode_t op,
                                         input int unsigned arg = 0);
	core_pkg::instr_t w;
	w.opcode  = op;
	w.operand = arg[core_pkg::OPERAND_W-1:0];
	return w;
endfunction

function automatic void emit(ref prog_t prog, input core_pkg::opcode_t op,
                             input int unsigned arg = 0);
	prog.push_back(ins(op, arg));
endfunction

// Address the next emitted word will get
function automatic int unsigned here(const ref prog_t prog);
	return prog.size();
endfunction

// Final self loop marks the end
function automatic void halt(ref prog_t prog);
	emit(prog, core_pkg::JMP, prog.size());
endfunction

// -----------------------------------------------
// Reference model
// -----------------------------------------------
function automatic io_exp_q_t ref_run(input prog_t prog, input dmem_img_t dmem,
                                      input core_pkg::data_t io_val,
                                      output port_q_t rd_q);
	io_exp_q_t        exp_q;
	core_pkg::data_t  dstk[$];
	int unsigned      rstk[$];
	core_pkg::data_t  acc;
	core_pkg::data_t  opnd;
	core_pkg::instr_t w;
	int unsigned      pc;
	int unsigned      arg;
	int unsigned      steps;
	acc   = '0;
	pc    = 0;
	steps = 0;
	rd_q.delete();
	while (pc < prog.size() && steps < 100000) begin
		w    = prog[pc];
		arg  = w.operand;
		opnd = dmem[arg];
		steps++;
		pc++;
		case (w.opcode)
			core_pkg::LOD: acc = opnd;
			core_pkg::SET: dmem[arg] = acc;
			core_pkg::PSH: dstk.push_back(acc);
			core_pkg::POP: acc = dstk.pop_back();
			// Port input is the same value on every port
			core_pkg::INN: begin
				acc = io_val;
				rd_q.push_back(arg[core_pkg::PORT_W-1:0]);
			end
			core_pkg::OUT: exp_q.push_back('{port: arg[core_pkg::PORT_W-1:0], data: acc});
			core_pkg::ADD: acc = acc + opnd;
			core_pkg::SUB: acc = acc - opnd;
			core_pkg::AND: acc = acc & opnd;
			core_pkg::ORR: acc = acc | opnd;
			core_pkg::XOR: acc = acc ^ opnd;
			core_pkg::SHL: acc = acc << opnd[3:0];
			core_pkg::SHR: acc = acc >> opnd[3:0];
			core_pkg::JMP: begin
				// Jump to itself ends the run
				if (arg == pc - 1) begin
					break;
				end
				pc = arg;
			end
			core_pkg::JIZ: begin
				if (acc == '0) begin
					pc = arg;
				end
			end
			core_pkg::CAL: begin
				rstk.push_back(pc);
				pc = arg;
			end
			core_pkg::RET: pc = rstk.pop_back();
			default: ;
		endcase
	end
	return exp_q;
endfunction

`endif

//--- sim/core_tb.sv
// -----------------------------------------------
// Testbench for the accumulator core
// Runs small programs and checks each port access
// against the ISA reference model
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_tb;

import core_pkg::*;

`include "core_tb_ref.svh"

localparam int CLK_PERIOD  = 4;
localparam int NUM_TESTS   = 4;
localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;
localparam int IMEM_WORDS  = 2**IADDR_W;

// -----------------------------------------------
// DUT signals and memories
// -----------------------------------------------
logic                clk = 1'b0;
logic                rst;
instr_t              instr = '0;
data_t               dmem_rd_data = '0;
data_t               io_in;
iaddr_t              instr_addr;
logic [DADDR_W-1:0]  dmem_rd_addr;
dmem_wr_t            dmem_wr;
io_rd_t              io_rd;
io_wr_t              io_wr;

instr_t              imem [IMEM_WORDS];
dmem_img_t           dmem;

// Expected port accesses and end of test tracking
io_exp_q_t           exp_q;
port_q_t             rd_q;
iaddr_t              final_pc;
int unsigned         loop_count;
int unsigned         n_writes;
logic                test_done = 1'b0;
logic [31:0]         rng;

always #(CLK_PERIOD / 2) clk = ~clk;

core #(
	.RSTACK_DEPTH (RSTACK_DEPTH),
	.DSTACK_DEPTH (DSTACK_DEPTH)
) uut (
	.clk          (clk),
	.rst          (rst),
	.instr        (instr),
	.dmem_rd_data (dmem_rd_data),
	.io_in        (io_in),
	.instr_addr   (instr_addr),
	.dmem_rd_addr (dmem_rd_addr),
	.dmem_wr      (dmem_wr),
	.io_rd        (io_rd),
	.io_wr        (io_wr)
);

// Synchronous instruction ROM
always @(posedge clk) begin
	instr <= imem[instr_addr];
end

// Write-first data RAM
always @(posedge clk) begin
	if (dmem_wr.en) begin
		dmem[dmem_wr.addr] = dmem_wr.data;
	end
	dmem_rd_data <= dmem[dmem_rd_addr];
end

// -----------------------------------------------
// Helpers
// -----------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Background data distinct at every address
function automatic dmem_img_t base_image();
	dmem_img_t   img;
	int unsigned a;
	for (a = 0; a < 2**DADDR_W; a++) begin
		img[a] = data_t'((a * 40503) ^ 16'h3c5a);
	end
	return img;
endfunction

task automatic abort_run();
	$display("Simulation failed");
	$fatal(1, "run aborted after a failed check");
endtask

task automatic check_port(input port_t got, input port_t want, input string what);
	if (got !== want) begin
		$display("[ERROR] %0t ns: %s port %0d, expected %0d", $time, what, got, want);
		abort_run();
	end
endtask

task automatic check_data(input data_t got, input data_t want);
	if (got !== want) begin
		$display("[ERROR] %0t ns: I/O write data %h, expected %h", $time, got, want);
		abort_run();
	end
endtask

task automatic check_addr(input iaddr_t got, input iaddr_t want);
	if (got !== want) begin
		$display("[ERROR] %0t ns: instr_addr %0d, expected %0d", $time, got, want);
		abort_run();
	end
endtask

task automatic check_strobe(input logic got, input logic want, input string name);
	if (got !== want) begin
		$display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, want);
		abort_run();
	end
endtask

// Fetch parked at 0 with all strobes low
task automatic check_reset_state();
	check_addr(instr_addr, '0);
	check_strobe(io_wr.en, 1'b0, "io_wr.en");
	check_strobe(dmem_wr.en, 1'b0, "dmem_wr.en");
	check_strobe(io_rd.req, 1'b0, "io_rd.req");
endtask

// -----------------------------------------------
// Compare process
// -----------------------------------------------
always @(posedge clk) begin : compare_io
	io_exp_t want;
	port_t   want_port;
	if (rst) begin
		loop_count = 0;
		test_done  = 1'b0;
	end else begin
		// Port reads are issued in decode
		if (io_rd.req) begin
			if (rd_q.size() == 0) begin
				$display("[ERROR] %0t ns: I/O read of port %0d with no read expected",
				         $time, io_rd.port);
				abort_run();
			end else begin
				want_port = rd_q.pop_front();
				check_port(io_rd.port, want_port, "I/O read");
			end
		end
		if (io_wr.en) begin
			if (exp_q.size() == 0) begin
				$display("[ERROR] %0t ns: I/O write to port %0d with no write expected",
				         $time, io_wr.port);
				abort_run();
			end else begin
				want = exp_q.pop_front();
				check_port(io_wr.port, want.port, "I/O write");
				check_data(io_wr.data, want.data);
				n_writes++;
			end
		end
		// Done once parked in the final loop
		if (exp_q.size() == 0 && rd_q.size() == 0 && instr_addr == final_pc) begin
			loop_count++;
		end else begin
			loop_count = 0;
		end
		if (loop_count >= 4) begin
			test_done = 1'b1;
		end
	end
end

// -----------------------------------------------
// Program runner
// -----------------------------------------------
task automatic run_program(input prog_t prog, input dmem_img_t img,
                           input int unsigned last_pc, input string name);
	int unsigned a;
	data_t       io_val;
	rng    = xorshift32(rng);
	io_val = rng[15:0];
	@(posedge clk);
	rst   <= 1'b1;
	io_in <= io_val;
	// Unused words jump to themselves
	for (a = 0; a < IMEM_WORDS; a++) begin
		imem[a] = (a < prog.size()) ? prog[a] : ins(JMP, a);
	end
	dmem     = img;
	exp_q    = ref_run(prog, img, io_val, rd_q);
	final_pc = iaddr_t'(last_pc);
	n_writes = 0;
	repeat (4) begin
		@(posedge clk);
		check_reset_state();
	end
	rst <= 1'b0;
	// First cycle out of reset
	@(posedge clk);
	check_reset_state();
	wait (test_done);
	$display("%s: %0d port writes checked", name, n_writes);
endtask

// -----------------------------------------------
// Tests
// -----------------------------------------------
task automatic test_alu();
	prog_t       prog;
	dmem_img_t   img;
	opcode_t     ops [7];
	int unsigned i;
	int unsigned last_pc;
	ops = '{ADD, SUB, AND, ORR, XOR, SHL, SHR};
	img = base_image();
	for (i = 0; i < 8; i++) begin
		rng         = xorshift32(rng);
		img[16 + i] = rng[15:0];
	end
	emit(prog, LOD, 16);
	// Chain every op and dump each result
	for (i = 0; i < 7; i++) begin
		emit(prog, ops[i], 17 + i);
		emit(prog, OUT, i);
	end
	last_pc = here(prog);
	halt(prog);
	run_program(prog, img, last_pc, "ALU operations");
endtask

task automatic test_mem_io();
	prog_t       prog;
	dmem_img_t   img;
	int unsigned last_pc;
	img = base_image();
	emit(prog, INN, 1);
	emit(prog, OUT, 1);
	emit(prog, INN, 5);
	emit(prog, OUT, 5);
	emit(prog, INN, 6);
	// Store then load straight back
	emit(prog, SET, 40);
	emit(prog, LOD, 40);
	emit(prog, OUT, 2);
	emit(prog, ADD, 40);
	emit(prog, SET, 41);
	emit(prog, LOD, 41);
	emit(prog, ADD, 42);
	emit(prog, OUT, 3);
	last_pc = here(prog);
	halt(prog);
	run_program(prog, img, last_pc, "Memory and I/O");
endtask

task automatic test_branch();
	prog_t       prog;
	dmem_img_t   img;
	int unsigned loop_top;
	int unsigned patch_at;
	int unsigned last_pc;
	img     = base_image();
	rng     = xorshift32(rng);
	img[50] = data_t'(2 + rng % 5);
	img[51] = 16'd1;
	img[52] = 16'd0;
	emit(prog, LOD, 50);
	// Countdown with one write per pass
	loop_top = here(prog);
	emit(prog, OUT, 4);
	emit(prog, SUB, 51);
	patch_at = here(prog);
	emit(prog, JIZ, 0);
	emit(prog, JMP, loop_top);
	prog[patch_at] = ins(JIZ, here(prog));
	// Skipped write
	patch_at = here(prog);
	emit(prog, JMP, 0);
	emit(prog, OUT, 6);
	prog[patch_at] = ins(JMP, here(prog));
	emit(prog, OUT, 7);
	// Taken JIZ right after a zero load
	emit(prog, LOD, 52);
	patch_at = here(prog);
	emit(prog, JIZ, 0);
	emit(prog, OUT, 5);
	prog[patch_at] = ins(JIZ, here(prog));
	emit(prog, OUT, 3);
	last_pc = here(prog);
	halt(prog);
	run_program(prog, img, last_pc, "Branches");
endtask

task automatic test_subroutine();
	prog_t       prog;
	dmem_img_t   img;
	int unsigned i;
	int unsigned cal_at;
	int unsigned last_pc;
	int unsigned s1;
	int unsigned s2;
	int unsigned s3;
	img = base_image();
	for (i = 60; i < 68; i++) begin
		rng    = xorshift32(rng);
		img[i] = rng[15:0];
	end
	emit(prog, LOD, 60);
	cal_at = here(prog);
	emit(prog, CAL, 0);
	emit(prog, OUT, 0);
	// Three pushes come back reversed on pop
	emit(prog, LOD, 61);
	emit(prog, PSH);
	emit(prog, LOD, 62);
	emit(prog, PSH);
	emit(prog, LOD, 63);
	emit(prog, PSH);
	emit(prog, LOD, 64);
	for (i = 1; i < 4; i++) begin
		emit(prog, POP);
		emit(prog, OUT, i);
	end
	last_pc = here(prog);
	halt(prog);
	// Innermost routine first
	s3 = here(prog);
	emit(prog, XOR, 67);
	emit(prog, OUT, 5);
	emit(prog, RET);
	s2 = here(prog);
	emit(prog, ADD, 66);
	emit(prog, OUT, 4);
	emit(prog, CAL, s3);
	emit(prog, OUT, 4);
	emit(prog, RET);
	s1 = here(prog);
	emit(prog, ADD, 65);
	emit(prog, OUT, 6);
	emit(prog, CAL, s2);
	emit(prog, OUT, 6);
	emit(prog, RET);
	prog[cal_at] = ins(CAL, s1);
	run_program(prog, img, last_pc, "Subroutines and stack");
endtask

// -----------------------------------------------
// Main sequence and watchdog
// -----------------------------------------------
initial begin
	rst   <= 1'b1;
	io_in <= '0;
	rng   = 32'heecd3579;
	test_alu();
	test_mem_io();
	test_branch();
	test_subroutine();
	$display("Simulation completed successfully");
	$finish;
end

initial begin : watchdog
	#(WATCHDOG_NS);
	$display("Watchdog expired, a program never reached its final loop");
	$display("Simulation failed");
	$fatal(1, "timeout");
end

endmodule

`default_nettype wire

//--- acc_core.f
+incdir+include
source/core_pkg.sv
source/lifo.sv
source/alu.sv
source/instr_fetch.sv
source/instr_dec.sv
source/exec_unit.sv
source/core.sv
sim/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module core_tb -f acc_core.f -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/core_tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
